/* hdl/rename_defines.svh */
// Sizing for the rename slice. PHYS_REGS may range from 40 to 128.
// PHYS_REGS must stay above ARCH_REGS, since the excess forms the free list
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Physical register count
// Tag 0 is reserved as the x0 sink
`define PHYS_REGS 64

// Architectural registers of RV32I
`define ARCH_REGS 32

// Data path width
`define XLEN 32

`endif

/* hdl/rename_pkg.sv */
// Shared types for the rename slice. Only the RV32I ALU subset is decoded.
package rename_pkg;

    `include "rename_defines.svh"

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0] areg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Major opcodes handled by dispatch
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm12;
        areg_t       rs1;
        logic [2:0]  funct3;
        areg_t       rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Same 32 bits, seen as R-type or I-type
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_t;

endpackage

/* hdl/cdb_if.sv */
// Single result bus from the ALU. Fields other than valid mean nothing
// while valid is low.
`timescale 1ns/1ps

interface cdb_if;
    import rename_pkg::*;

    // One-cycle strobe per result
    logic  valid;
    // Destination physical register
    preg_t tag;
    // Mapping displaced at rename, freed on this write
    preg_t old_tag;
    // Architectural destination, for write-back reporting
    areg_t rd;
    word_t value;

    // ALU side
    modport source (output valid, tag, old_tag, rd, value);

    // Register file and dispatch listen
    modport sink (input valid, tag, old_tag, rd, value);

endinterface

/* hdl/prf_read_if.sv */
// Dispatch read port of the physical register file. Answers are
// combinational and already include the CDB bypass.
`timescale 1ns/1ps

interface prf_read_if;
    import rename_pkg::*;

    // Requests from dispatch
    preg_t rs1_tag;
    preg_t rs2_tag;

    // Answers from the register file
    word_t rs1_value;
    word_t rs2_value;
    logic  rs1_busy;
    logic  rs2_busy;

    modport requester (
        output rs1_tag, rs2_tag,
        input  rs1_value, rs2_value, rs1_busy, rs2_busy
    );

    modport responder (
        input  rs1_tag, rs2_tag,
        output rs1_value, rs2_value, rs1_busy, rs2_busy
    );

endinterface

/* hdl/free_list.sv */
// Circular FIFO of free physical tags. Reset fills it with tags ARCH_REGS
// to PHYS_REGS-1, and head is valid only while empty is low.
`timescale 1ns/1ps
`include "rename_defines.svh"

module free_list (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  rename_pkg::preg_t push_tag,
    input  logic              pop,
    output rename_pkg::preg_t head,
    output logic              empty
);
    import rename_pkg::*;

    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    preg_t            slots [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            // Unmapped tags, in order
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= preg_t'(`ARCH_REGS + i);
            end
            rd_ptr <= '0;
            // Full at reset, so the write pointer has wrapped to zero
            wr_ptr <= '0;
            count  <= CNT_W'(DEPTH);
        end else begin
            if (push) begin
                slots[wr_ptr] <= push_tag;
                wr_ptr        <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head  = slots[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Dispatch must see empty before it asks for a tag
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("free list popped while empty");

    // Tag accounting broken if a returned tag finds no room
    assert property (@(posedge clk) disable iff (rst) (push && !pop) |-> !full)
        else $error("free list pushed while full");

endmodule

/* hdl/dispatch_stage.sv */
// In-order rename and issue, one instruction per cycle. Unsupported opcodes
// are consumed silently; writes to x0 issue with tag 0 and allocate nothing.
`timescale 1ns/1ps
`include "rename_defines.svh"

module dispatch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  rename_pkg::inst_word_t inst,
    output logic                  stall,
    prf_read_if.requester         rd_port,
    cdb_if.sink                   cdb,
    output logic                  alloc_en,
    output rename_pkg::preg_t     alloc_tag,
    output logic                  issue_valid,
    output rename_pkg::alu_op_t   issue_op,
    output rename_pkg::word_t     issue_a,
    output rename_pkg::word_t     issue_b,
    output rename_pkg::preg_t     issue_tag,
    output rename_pkg::preg_t     issue_old_tag,
    output rename_pkg::areg_t     issue_rd
);
    import rename_pkg::*;

    // Architectural to physical map
    preg_t rat [`ARCH_REGS];

    logic    is_r;
    logic    is_i;
    logic    f3_ok;
    logic    supported;
    logic    need_alloc;
    logic    accept;
    logic    fl_empty;
    preg_t   fl_head;
    alu_op_t op;
    areg_t   rd;
    word_t   imm_sext;

    // Funct3 values shared by both formats: ADD/SUB, XOR, OR, AND
    assign f3_ok = (inst.r.funct3 == 3'b000) || (inst.r.funct3 == 3'b100) ||
                   (inst.r.funct3 == 3'b110) || (inst.r.funct3 == 3'b111);

    // R-type only accepts funct7 0, or 0x20 for SUB
    assign is_r = (inst.r.opcode == OPC_REG) && f3_ok &&
                  ((inst.r.funct7 == 7'h00) ||
                   (inst.r.funct7 == 7'h20 && inst.r.funct3 == 3'b000));
    assign is_i = (inst.i.opcode == OPC_IMM) && f3_ok;
    assign supported = is_r || is_i;

    always_comb begin
        case (inst.r.funct3)
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            // Only R-type can subtract
            default: op = (is_r && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    assign rd       = inst.i.rd;
    assign imm_sext = {{(`XLEN - 12){inst.i.imm12[11]}}, inst.i.imm12};

    // Source lookup; register file bypasses the CDB for us
    assign rd_port.rs1_tag = rat[inst.r.rs1];
    assign rd_port.rs2_tag = rat[inst.r.rs2];

    // x0 is never renamed
    assign need_alloc = supported && (rd != '0);

    // rs2 only matters for R-type
    assign stall = inst_valid && supported &&
                   (rd_port.rs1_busy || (is_r && rd_port.rs2_busy) ||
                    (need_alloc && fl_empty));

    assign accept = inst_valid && !stall;

    assign alloc_en  = accept && need_alloc;
    assign alloc_tag = fl_head;

    // Issue goes straight into ALU stage 1
    assign issue_valid   = accept && supported;
    assign issue_op      = op;
    assign issue_a       = rd_port.rs1_value;
    assign issue_b       = is_r ? rd_port.rs2_value : imm_sext;
    assign issue_tag     = need_alloc ? fl_head : '0;
    assign issue_old_tag = need_alloc ? rat[rd] : '0;
    assign issue_rd      = rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                rat[i] <= preg_t'(i);
            end
        end else if (alloc_en) begin
            rat[rd] <= fl_head;
        end
    end

    // Displaced tag comes back when its successor writes
    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .push     (cdb.valid && (cdb.old_tag != '0)),
        .push_tag (cdb.old_tag),
        .pop      (alloc_en),
        .head     (fl_head),
        .empty    (fl_empty)
    );

endmodule

/* hdl/phys_reg_file.sv */
// Physical values and busy bits. Tag 0 reads zero and is never written;
// all values clear to zero at reset and reads see the CDB in the same cycle.
`timescale 1ns/1ps
`include "rename_defines.svh"

module phys_reg_file (
    input  logic              clk,
    input  logic              rst,
    prf_read_if.responder     rd_port,
    cdb_if.sink               cdb,
    input  logic              alloc_en,
    input  rename_pkg::preg_t alloc_tag
);
    import rename_pkg::*;

    word_t values [`PHYS_REGS];
    logic  busy   [`PHYS_REGS];
    logic  cdb_we;

    // Tag 0 results are the x0 sink and are dropped
    assign cdb_we = cdb.valid && (cdb.tag != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                values[i] <= '0;
                busy[i]   <= 1'b0;
            end
        end else begin
            if (cdb_we) begin
                values[cdb.tag] <= cdb.value;
                busy[cdb.tag]   <= 1'b0;
            end
            // Never the same tag as the CDB write
            if (alloc_en) begin
                busy[alloc_tag] <= 1'b1;
            end
        end
    end

    function automatic word_t read_value(input preg_t t);
        if (t == '0) begin
            return '0;
        end
        // Result landing this cycle wins over the stored copy
        if (cdb_we && (cdb.tag == t)) begin
            return cdb.value;
        end
        return values[t];
    endfunction

    function automatic logic read_busy(input preg_t t);
        if (cdb_we && (cdb.tag == t)) begin
            return 1'b0;
        end
        return busy[t];
    endfunction

    always_comb begin
        rd_port.rs1_value = read_value(rd_port.rs1_tag);
        rd_port.rs2_value = read_value(rd_port.rs2_tag);
        rd_port.rs1_busy  = read_busy(rd_port.rs1_tag);
        rd_port.rs2_busy  = read_busy(rd_port.rs2_tag);
    end

    // Free list must never hand out the zero register
    assert property (@(posedge clk) disable iff (rst) alloc_en |-> (alloc_tag != '0))
        else $error("tag 0 allocated");

    // Every ALU result must target a tag renamed earlier and still pending
    assert property (@(posedge clk) disable iff (rst) cdb_we |-> busy[cdb.tag])
        else $error("CDB write to tag %0d which is not busy", cdb.tag);

endmodule

/* hdl/alu_unit.sv */
// Two-stage ALU with fixed latency. The CDB is driven from stage 2
// registers, so a result appears two edges after issue.
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  rename_pkg::alu_op_t issue_op,
    input  rename_pkg::word_t   issue_a,
    input  rename_pkg::word_t   issue_b,
    input  rename_pkg::preg_t   issue_tag,
    input  rename_pkg::preg_t   issue_old_tag,
    input  rename_pkg::areg_t   issue_rd,
    cdb_if.source               cdb
);
    import rename_pkg::*;

    // Stage 1, operands as issued
    logic    s1_valid;
    alu_op_t s1_op;
    word_t   s1_a;
    word_t   s1_b;
    preg_t   s1_tag;
    preg_t   s1_old_tag;
    areg_t   s1_rd;

    // Stage 2, result registers
    logic    s2_valid;
    preg_t   s2_tag;
    preg_t   s2_old_tag;
    areg_t   s2_rd;
    word_t   s2_value;

    word_t   result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op      <= issue_op;
        s1_a       <= issue_a;
        s1_b       <= issue_b;
        s1_tag     <= issue_tag;
        s1_old_tag <= issue_old_tag;
        s1_rd      <= issue_rd;
        s2_tag     <= s1_tag;
        s2_old_tag <= s1_old_tag;
        s2_rd      <= s1_rd;
        s2_value   <= result;
    end

    always_comb begin
        case (s1_op)
            ALU_SUB: result = s1_a - s1_b;
            ALU_AND: result = s1_a & s1_b;
            ALU_OR:  result = s1_a | s1_b;
            ALU_XOR: result = s1_a ^ s1_b;
            default: result = s1_a + s1_b;
        endcase
    end

    assign cdb.valid   = s2_valid;
    assign cdb.tag     = s2_tag;
    assign cdb.old_tag = s2_old_tag;
    assign cdb.rd      = s2_rd;
    assign cdb.value   = s2_value;

endmodule

/* hdl/rename_core_top.sv */
// Rename and execute slice. Hold inst while stall is high; wb_valid pulses
// once per supported instruction, two edges after acceptance, in order.
`timescale 1ns/1ps

module rename_core_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        stall,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_value
);
    import rename_pkg::*;

    cdb_if      cdb_bus ();
    prf_read_if prf_rd ();

    logic    alloc_en;
    preg_t   alloc_tag;
    logic    issue_valid;
    alu_op_t issue_op;
    word_t   issue_a;
    word_t   issue_b;
    preg_t   issue_tag;
    preg_t   issue_old_tag;
    areg_t   issue_rd;

    dispatch_stage u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst          (inst_word_t'(inst)),
        .stall         (stall),
        .rd_port       (prf_rd),
        .cdb           (cdb_bus),
        .alloc_en      (alloc_en),
        .alloc_tag     (alloc_tag),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_old_tag (issue_old_tag),
        .issue_rd      (issue_rd)
    );

    phys_reg_file u_prf (
        .clk       (clk),
        .rst       (rst),
        .rd_port   (prf_rd),
        .cdb       (cdb_bus),
        .alloc_en  (alloc_en),
        .alloc_tag (alloc_tag)
    );

    alu_unit u_alu (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_old_tag (issue_old_tag),
        .issue_rd      (issue_rd),
        .cdb           (cdb_bus)
    );

    // Write-back is the CDB beat itself
    assign wb_valid = cdb_bus.valid;
    assign wb_rd    = cdb_bus.rd;
    assign wb_value = cdb_bus.value;

endmodule

/* testbench/tb_rename_core.sv */
// Directed tests for the rename slice, checked against an architectural register model.
// The model runs at send time, so write-backs must come back in the order they were sent.
`timescale 1ns/1ps

module tb_rename_core;

    // About 400 instructions at up to 4 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;

    // Architectural state as the model sees it
    logic [31:0] arch [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    logic [31:0] rng_state;
    string       cur_test;
    int          err_count;
    int          test_count;
    int          cycle_count;

    rename_core_top UUT (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Hard stop for a hung pipeline
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles during %s", TIMEOUT_CYCLES, cur_test);
            $display("Simulation failed");
            $finish;
        end
    end

    // Outputs are registered, so the falling edge sees them stable
    always @(negedge clk) begin : wb_monitor
        logic [4:0]  want_rd;
        logic [31:0] want_val;
        if (wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                $display("Unexpected write-back in %s: rd %0d value %h",
                         cur_test, wb_rd, wb_value);
                err_count++;
            end else begin
                want_rd  = exp_rd_q.pop_front();
                want_val = exp_val_q.pop_front();
                if (wb_rd !== want_rd) begin
                    $display("FAIL %s: rd expected %0d actual %0d", cur_test, want_rd, wb_rd);
                    err_count++;
                end
                if (wb_value !== want_val) begin
                    $display("FAIL %s: value expected %h actual %h",
                             cur_test, want_val, wb_value);
                    err_count++;
                end
            end
        end
    end

    // RV32I semantics of the supported subset
    function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic sub,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Present on the falling edge, hold while stalled
    // Stall is settled 1 ns later and stays put until the rising edge
    task automatic send_word(input logic [31:0] word);
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = word;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic run_r(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] val;
        val = ref_result(f3, sub, arch[rs1], arch[rs2]);
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(val);
        if (rd != 5'd0) begin
            arch[rd] = val;
        end
        send_word(encode_r(sub ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
    endtask

    task automatic run_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        logic [31:0] val;
        val = ref_result(f3, 1'b0, arch[rs1], {{20{imm[11]}}, imm});
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(val);
        if (rd != 5'd0) begin
            arch[rd] = val;
        end
        send_word(encode_i(imm, rs1, f3, rd));
    endtask

    // Release the input, let the pipeline empty, report the test
    task automatic close_test(input int errs_before);
        int waited;
        @(negedge clk);
        inst_valid = 1'b0;
        waited = 0;
        #1;
        while (exp_rd_q.size() != 0 && waited < 10) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%s: %0d write-backs never arrived", cur_test, exp_rd_q.size());
            err_count++;
            exp_rd_q.delete();
            exp_val_q.delete();
        end
        test_count++;
        $display("Test %s finished with %0d errors", cur_test, err_count - errs_before);
    endtask

    task automatic reset_immediates();
        int errs;
        errs = err_count;
        cur_test = "reset_immediates";
        // Idle cycles, where the monitor flags any stray write-back
        // Nothing is offered yet, so stall has to stay low
        repeat (5) begin
            @(negedge clk);
            #1;
            if (stall !== 1'b0) begin
                $display("%s: stall high while no instruction is offered", cur_test);
                err_count++;
            end
        end
        run_i(3'b000, 5'd1, 5'd0, 12'h7ff);
        run_i(3'b000, 5'd2, 5'd0, 12'h800);
        run_i(3'b000, 5'd3, 5'd0, 12'h123);
        close_test(errs);
    endtask

    task automatic independent_ops();
        int errs;
        errs = err_count;
        cur_test = "independent_ops";
        run_i(3'b000, 5'd5, 5'd0, 12'hfff);
        run_i(3'b000, 5'd6, 5'd0, 12'h5a3);
        run_r(3'b000, 1'b0, 5'd20, 5'd1, 5'd3);
        run_r(3'b000, 1'b1, 5'd21, 5'd3, 5'd2);
        run_r(3'b111, 1'b0, 5'd22, 5'd5, 5'd6);
        run_r(3'b110, 1'b0, 5'd23, 5'd2, 5'd3);
        run_r(3'b100, 1'b0, 5'd24, 5'd5, 5'd1);
        run_i(3'b111, 5'd25, 5'd5, 12'h0f0);
        run_i(3'b110, 5'd26, 5'd3, 12'h804);
        run_i(3'b100, 5'd27, 5'd6, 12'hfff);
        close_test(errs);
    endtask

    // Back to back dependence, resolved through busy stalls and the bypass
    task automatic dependency_chain();
        int errs;
        errs = err_count;
        cur_test = "dependency_chain";
        run_i(3'b000, 5'd10, 5'd0, 12'h003);
        run_r(3'b000, 1'b0, 5'd11, 5'd10, 5'd10);
        run_i(3'b100, 5'd12, 5'd11, 12'h055);
        run_r(3'b000, 1'b1, 5'd13, 5'd12, 5'd10);
        run_r(3'b110, 1'b0, 5'd14, 5'd13, 5'd11);
        run_i(3'b000, 5'd10, 5'd14, 12'hff9);
        run_r(3'b111, 1'b0, 5'd11, 5'd10, 5'd14);
        run_r(3'b000, 1'b0, 5'd11, 5'd11, 5'd11);
        close_test(errs);
    endtask

    task automatic x0_writes();
        int errs;
        errs = err_count;
        cur_test = "x0_writes";
        run_i(3'b000, 5'd0, 5'd0, 12'h07b);
        run_r(3'b000, 1'b0, 5'd0, 5'd5, 5'd6);
        run_i(3'b000, 5'd9, 5'd0, 12'h000);
        run_r(3'b000, 1'b0, 5'd9, 5'd0, 5'd5);
        close_test(errs);
    endtask

    // Load, MUL, SLTI and SLL are all outside the subset
    task automatic unsupported_opcodes();
        int errs;
        errs = err_count;
        cur_test = "unsupported_opcodes";
        send_word(32'h0002a283);
        send_word(encode_r(7'h01, 5'd6, 5'd5, 3'b000, 5'd5));
        send_word(encode_i(12'h001, 5'd5, 3'b010, 5'd6));
        send_word(encode_r(7'h00, 5'd6, 5'd5, 3'b001, 5'd5));
        send_word(32'h00000000);
        run_r(3'b000, 1'b0, 5'd15, 5'd5, 5'd6);
        run_r(3'b100, 1'b0, 5'd16, 5'd6, 5'd15);
        close_test(errs);
    endtask

    // Far more renames than the free list holds, so tags must be recycled
    task automatic random_stream();
        int          errs;
        int          kind;
        logic [31:0] r;
        errs = err_count;
        cur_test = "random_stream";
        for (int n = 0; n < 300; n++) begin
            kind = int'(next_random() % 32'd9);
            r    = next_random();
            case (kind)
                0: run_r(3'b000, 1'b0, r[4:0], r[9:5], r[14:10]);
                1: run_r(3'b000, 1'b1, r[4:0], r[9:5], r[14:10]);
                2: run_r(3'b111, 1'b0, r[4:0], r[9:5], r[14:10]);
                3: run_r(3'b110, 1'b0, r[4:0], r[9:5], r[14:10]);
                4: run_r(3'b100, 1'b0, r[4:0], r[9:5], r[14:10]);
                5: run_i(3'b000, r[4:0], r[9:5], r[31:20]);
                6: run_i(3'b111, r[4:0], r[9:5], r[31:20]);
                7: run_i(3'b110, r[4:0], r[9:5], r[31:20]);
                default: run_i(3'b100, r[4:0], r[9:5], r[31:20]);
            endcase
        end
        close_test(errs);
    endtask

    initial begin
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = 32'h0;
        rng_state   = 32'hb8f383ad;
        err_count   = 0;
        test_count  = 0;
        cycle_count = 0;
        cur_test    = "reset";
        for (int i = 0; i < 32; i++) begin
            arch[i] = 32'h0;
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        reset_immediates();
        independent_ops();
        dependency_chain();
        x0_writes();
        unsupported_opcodes();
        random_stream();

        $display("Tests run: %0d, errors: %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/rename_pkg.sv
hdl/cdb_if.sv
hdl/prf_read_if.sv
hdl/free_list.sv
hdl/dispatch_stage.sv
hdl/phys_reg_file.sv
hdl/alu_unit.sv
hdl/rename_core_top.sv
testbench/tb_rename_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rename slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
    --top-module tb_rename_core --Mdir obj_dir -o tb_rename_core

./obj_dir/tb_rename_core | tee sim.log

# The testbench prints its verdict on a line of its own
grep -q "^Simulation passed$" sim.log
echo "Run passed"
